// File: logic/vidpipe_pkg.sv
package vidpipe_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and pixel types
	//////////////////////////////////////////////////////////////////////

	// Bits per frame dimension, so 4095x4095 at most
	localparam int LGDIM = 12;

	// Frames-per-second readback width
	localparam int FPS_BITS = 8;

	typedef logic [LGDIM-1:0] dim_t;

	// Red in the top byte, blue in the bottom
	typedef logic [23:0] rgb_t;

	// All ones is fully transparent
	typedef logic [1:0] alpha_t;

	// Black pixels get treated as see-through
	localparam rgb_t TRANSPARENT = 24'h00_0000;
	localparam alpha_t ALPHA_CLEAR = 2'b11;

	// Frame size out of reset
	localparam dim_t DEFAULT_WIDTH = 12'd640;
	localparam dim_t DEFAULT_HEIGHT = 12'd480;

	//////////////////////////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////////////////////////

	// Anything not listed reads zero and drops writes
	typedef enum logic [3:0] {
		ADR_CONTROL = 4'h0,
		ADR_SIZE = 4'h8,
		ADR_FPS = 4'hf
	} reg_addr_e;

	// Configuration from the register file to the stream stages
	typedef struct packed {
		dim_t width;
		dim_t height;
		alpha_t alpha;
	} vid_cfg_t;

	// Framer output beat
	typedef struct packed {
		logic vlast;
		logic hlast;
		rgb_t rgb;
	} vid_beat_t;

	// Output beat with alpha attached
	typedef struct packed {
		logic vlast;
		logic hlast;
		alpha_t alpha;
		rgb_t rgb;
	} vid_apix_t;

endpackage

// File: logic/vid_ctrl_regs.sv
module vid_ctrl_regs (
	input  logic i_clk,
	input  logic pix_reset_sys,
	// Bus slave side
	input  logic i_wb_cyc,
	input  logic i_wb_stb,
	input  logic i_wb_we,
	input  logic [3:0] i_wb_addr,
	input  logic [31:0] i_wb_data,
	input  logic [3:0] i_wb_sel,
	output logic o_wb_ack,
	output logic [31:0] o_wb_data,
	// Measured rate from the meter
	input  logic [vidpipe_pkg::FPS_BITS-1:0] i_fps,
	// Live configuration
	output vidpipe_pkg::vid_cfg_t o_cfg
);

	logic bus_req;
	logic wr_req;
	vidpipe_pkg::reg_addr_e wb_addr;
	logic pre_ack;
	logic [31:0] pre_data;
	logic [31:0] rd_word;

	// Bus never stalls, any strobe inside a cycle is a request
	assign bus_req = i_wb_cyc && i_wb_stb;
	assign wr_req = bus_req && i_wb_we;
	assign wb_addr = vidpipe_pkg::reg_addr_e'(i_wb_addr);

	//////////////////////////////////////////////////////////////////////
	// Register writes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			o_cfg.width <= vidpipe_pkg::DEFAULT_WIDTH;
			o_cfg.height <= vidpipe_pkg::DEFAULT_HEIGHT;
			o_cfg.alpha <= '0;
		end else if (wr_req) begin
			case (wb_addr)
				vidpipe_pkg::ADR_CONTROL: begin
					// Alpha lives in byte 1
					if (i_wb_sel[1])
						o_cfg.alpha <= i_wb_data[15:14];
				end
				vidpipe_pkg::ADR_SIZE: begin
					// Both low bytes needed for the width
					if (&i_wb_sel[1:0])
						o_cfg.width <= i_wb_data[0 +: vidpipe_pkg::LGDIM];
					// Height from the upper half-word
					if (&i_wb_sel[3:2])
						o_cfg.height <= i_wb_data[16 +: vidpipe_pkg::LGDIM];
				end
				default: begin
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read mux and acknowledge pipeline
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		rd_word = '0;
		case (wb_addr)
			vidpipe_pkg::ADR_CONTROL: rd_word[15:14] = o_cfg.alpha;
			vidpipe_pkg::ADR_SIZE: begin
				rd_word[16 +: vidpipe_pkg::LGDIM] = o_cfg.height;
				rd_word[0 +: vidpipe_pkg::LGDIM] = o_cfg.width;
			end
			vidpipe_pkg::ADR_FPS: rd_word[vidpipe_pkg::FPS_BITS-1:0] = i_fps;
			default: rd_word = '0;
		endcase
	end

	// Two ack stages, dropped together when the master ends the cycle
	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			pre_ack <= 1'b0;
			o_wb_ack <= 1'b0;
		end else if (!i_wb_cyc) begin
			pre_ack <= 1'b0;
			o_wb_ack <= 1'b0;
		end else begin
			pre_ack <= bus_req;
			o_wb_ack <= pre_ack;
		end
	end

	// First stage captures the word, second presents it with the ack
	always_ff @(posedge i_clk) begin
		if (bus_req && !i_wb_we)
			pre_data <= rd_word;
		if (pre_ack)
			o_wb_data <= pre_data;
	end

endmodule

// File: logic/vid_framer.sv
module vid_framer (
	input  logic i_clk,
	input  logic pix_reset_sys,
	// Programmed frame size
	input  vidpipe_pkg::dim_t i_width,
	input  vidpipe_pkg::dim_t i_height,
	// Raw pixel input
	input  logic i_pix_valid,
	input  vidpipe_pkg::rgb_t i_pixel,
	output logic o_pix_ready,
	// Framed stream out
	output logic o_valid,
	output vidpipe_pkg::vid_beat_t o_beat,
	input  logic i_ready
);

	vidpipe_pkg::dim_t col;
	vidpipe_pkg::dim_t row;
	vidpipe_pkg::dim_t last_col;
	vidpipe_pkg::dim_t last_row;
	logic accept;
	logic at_hlast;
	logic at_vlast;

	// Output stage empty or draining this cycle
	assign o_pix_ready = !o_valid || i_ready;
	assign accept = i_pix_valid && o_pix_ready;

	assign last_col = i_width - 1'b1;
	assign last_row = i_height - 1'b1;

	// End of line, and end of frame on the last line only
	assign at_hlast = (col == last_col);
	assign at_vlast = at_hlast && (row == last_row);

	//////////////////////////////////////////////////////////////////////
	// Position counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			col <= '0;
			row <= '0;
		end else if (accept) begin
			if (at_hlast) begin
				col <= '0;
				// Wrap back to the top after the last line
				row <= at_vlast ? '0 : row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output stage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys)
			o_valid <= 1'b0;
		else if (accept)
			o_valid <= 1'b1;
		else if (i_ready)
			o_valid <= 1'b0;
	end

	// Beat only changes on accept, so it stays put while stalled
	always_ff @(posedge i_clk) begin
		if (accept) begin
			o_beat.vlast <= at_vlast;
			o_beat.hlast <= at_hlast;
			o_beat.rgb <= i_pixel;
		end
	end

endmodule

// File: logic/vid_alpha_skid.sv
module vid_alpha_skid (
	input  logic i_clk,
	input  logic pix_reset_sys,
	// Programmed alpha
	input  vidpipe_pkg::alpha_t i_alpha,
	// Upstream beats from the framer
	input  logic i_valid,
	input  vidpipe_pkg::vid_beat_t i_beat,
	output logic o_ready,
	// Registered output
	output logic o_valid,
	output vidpipe_pkg::vid_apix_t o_beat,
	input  logic i_ready
);

	vidpipe_pkg::vid_apix_t in_pix;
	vidpipe_pkg::vid_apix_t skid_pix;
	logic skid_valid;
	logic load_out;

	// Alpha is attached on entry
	always_comb begin
		in_pix.vlast = i_beat.vlast;
		in_pix.hlast = i_beat.hlast;
		in_pix.rgb = i_beat.rgb;
		// Black goes fully see-through
		if (i_beat.rgb == vidpipe_pkg::TRANSPARENT)
			in_pix.alpha = vidpipe_pkg::ALPHA_CLEAR;
		else
			in_pix.alpha = i_alpha;
	end

	// Ready comes straight off a flop
	assign o_ready = !skid_valid;

	// Output register free or being emptied
	assign load_out = !o_valid || i_ready;

	//////////////////////////////////////////////////////////////////////
	// Skid entry
	//////////////////////////////////////////////////////////////////////

	// Catch the beat that arrives while the output is stuck
	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys)
			skid_valid <= 1'b0;
		else if (i_valid && o_ready && o_valid && !i_ready)
			skid_valid <= 1'b1;
		else if (i_ready)
			skid_valid <= 1'b0;
	end

	always_ff @(posedge i_clk) begin
		if (o_ready)
			skid_pix <= in_pix;
	end

	//////////////////////////////////////////////////////////////////////
	// Output entry
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys)
			o_valid <= 1'b0;
		else if (load_out)
			o_valid <= i_valid || skid_valid;
	end

	// Skid holds the older beat, so it goes first
	always_ff @(posedge i_clk) begin
		if (load_out)
			o_beat <= skid_valid ? skid_pix : in_pix;
	end

endmodule

// File: logic/vid_frame_rate.sv
module vid_frame_rate #(
	parameter int TICKS_PER_SEC = 100_000_000
) (
	input  logic i_clk,
	input  logic pix_reset_sys,
	// Output handshake, watched only
	input  logic i_valid,
	input  logic i_ready,
	input  logic i_hlast,
	input  logic i_vlast,
	// Frames in the last full second
	output logic [vidpipe_pkg::FPS_BITS-1:0] o_fps
);

	// Wide enough to reach TICKS_PER_SEC-1
	localparam int CW = (TICKS_PER_SEC > 2) ? $clog2(TICKS_PER_SEC) : 1;
	localparam logic [CW-1:0] LAST_TICK = CW'(TICKS_PER_SEC - 1);

	logic [CW-1:0] tick_cnt;
	logic pps;
	logic frame_end;
	// Top bit flags overflow past 255
	logic [vidpipe_pkg::FPS_BITS:0] frame_cnt;

	//////////////////////////////////////////////////////////////////////
	// Once-per-second pulse
	//////////////////////////////////////////////////////////////////////

	assign pps = (tick_cnt == LAST_TICK);

	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys)
			tick_cnt <= '0;
		else if (pps)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Frame counting
	//////////////////////////////////////////////////////////////////////

	// Last beat of a frame actually transferred
	assign frame_end = i_valid && i_ready && i_hlast && i_vlast;

	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			frame_cnt <= '0;
			o_fps <= '0;
		end else if (pps) begin
			// Frame end on the pulse belongs to the next window
			frame_cnt <= frame_end ? 9'd1 : 9'd0;
			// Saturate once the counter has overflowed
			o_fps <= frame_cnt[vidpipe_pkg::FPS_BITS] ? '1
				: frame_cnt[vidpipe_pkg::FPS_BITS-1:0];
		end else if (frame_end && !frame_cnt[vidpipe_pkg::FPS_BITS]) begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

endmodule

// File: logic/vidpipe.sv
module vidpipe #(
	parameter int TICKS_PER_SEC = 100_000_000
) (
	input  logic i_clk,
	input  logic pix_reset_sys,
	// Control bus
	input  logic i_wb_cyc,
	input  logic i_wb_stb,
	input  logic i_wb_we,
	input  logic [3:0] i_wb_addr,
	input  logic [31:0] i_wb_data,
	input  logic [3:0] i_wb_sel,
	output logic o_wb_ack,
	output logic [31:0] o_wb_data,
	// Raw pixels in
	input  logic i_pix_valid,
	input  vidpipe_pkg::rgb_t i_pixel,
	output logic o_pix_ready,
	// Video stream out
	output logic o_vid_valid,
	output vidpipe_pkg::vid_apix_t o_vid_beat,
	input  logic i_vid_ready
);

	vidpipe_pkg::vid_cfg_t cfg;
	logic [vidpipe_pkg::FPS_BITS-1:0] fps;

	// Framer to skid buffer
	logic frm_valid;
	logic frm_ready;
	vidpipe_pkg::vid_beat_t frm_beat;

	//////////////////////////////////////////////////////////////////////
	// Control registers
	//////////////////////////////////////////////////////////////////////

	vid_ctrl_regs u_ctrl_regs (
		.i_clk(i_clk), .pix_reset_sys(pix_reset_sys),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_addr(i_wb_addr), .i_wb_data(i_wb_data), .i_wb_sel(i_wb_sel),
		.o_wb_ack(o_wb_ack), .o_wb_data(o_wb_data),
		.i_fps(fps), .o_cfg(cfg)
	);

	//////////////////////////////////////////////////////////////////////
	// Stream stages
	//////////////////////////////////////////////////////////////////////

	// Raw pixels into tagged beats
	vid_framer u_framer (
		.i_clk(i_clk), .pix_reset_sys(pix_reset_sys),
		.i_width(cfg.width), .i_height(cfg.height),
		.i_pix_valid(i_pix_valid), .i_pixel(i_pixel), .o_pix_ready(o_pix_ready),
		.o_valid(frm_valid), .o_beat(frm_beat), .i_ready(frm_ready)
	);

	// Alpha tagging with a registered output
	vid_alpha_skid u_alpha_skid (
		.i_clk(i_clk), .pix_reset_sys(pix_reset_sys),
		.i_alpha(cfg.alpha),
		.i_valid(frm_valid), .i_beat(frm_beat), .o_ready(frm_ready),
		.o_valid(o_vid_valid), .o_beat(o_vid_beat), .i_ready(i_vid_ready)
	);

	// Meter sits on the output handshake
	vid_frame_rate #(
		.TICKS_PER_SEC(TICKS_PER_SEC)
	) u_frame_rate (
		.i_clk(i_clk), .pix_reset_sys(pix_reset_sys),
		.i_valid(o_vid_valid), .i_ready(i_vid_ready),
		.i_hlast(o_vid_beat.hlast), .i_vlast(o_vid_beat.vlast),
		.o_fps(fps)
	);

endmodule

// File: testbench/vidpipe_tb.sv
module vidpipe_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TICKS = 400;
	localparam int NUM_ROWS = 5;

	// One stimulus row
	typedef struct packed {
		vidpipe_pkg::dim_t width;
		vidpipe_pkg::dim_t height;
		vidpipe_pkg::alpha_t alpha;
		logic [7:0] frames;
		logic [7:0] drop_pct;
	} test_row_t;

	logic i_clk = 1'b0;
	logic pix_reset_sys = 1'b1;
	logic i_wb_cyc;
	logic i_wb_stb;
	logic i_wb_we;
	logic [3:0] i_wb_addr;
	logic [31:0] i_wb_data;
	logic [3:0] i_wb_sel;
	logic o_wb_ack;
	logic [31:0] o_wb_data;
	logic i_pix_valid;
	vidpipe_pkg::rgb_t i_pixel;
	logic o_pix_ready;
	logic o_vid_valid;
	vidpipe_pkg::vid_apix_t o_vid_beat;
	logic i_vid_ready = 1'b1;

	test_row_t rows [NUM_ROWS];
	// Expected beats, pushed by the source and walked by the monitor
	vidpipe_pkg::vid_apix_t exp_q[$];
	int rd_idx = 0;
	// Frame ends per one-second window
	int frame_ends [64];
	int edge_cnt = 0;
	int rel_base = 0;
	int limit = 0;
	int drop_pct = 0;
	int err_cnt = 0;
	int check_cnt = 0;
	int beat_err = 0;
	int src_seed = 32'hd62f_830e;
	int sink_seed = 32'hd62f_830e ^ 32'h0000_ffff;

	vidpipe #(.TICKS_PER_SEC(TICKS)) u_vidpipe (.*);

	always #20 i_clk = ~i_clk;

	// Edge counter that also bounds the run
	always @(posedge i_clk) begin
		edge_cnt <= edge_cnt + 1;
		if (limit > 0 && edge_cnt >= limit) begin
			$display("timeout after %0d cycles, stream or bus never finished", edge_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Sink drops ready at random
	always @(posedge i_clk) begin
		if (pix_reset_sys)
			i_vid_ready <= 1'b1;
		else
			i_vid_ready <= ({$random(sink_seed)} % 100) >= drop_pct;
	end

	//////////////////////////////////////////////////////////////////////
	// Output monitor
	//////////////////////////////////////////////////////////////////////

	// Valid and ready here means a transfer on the coming edge
	always @(negedge i_clk) begin
		int ofs;
		if (!pix_reset_sys && o_vid_valid && i_vid_ready) begin
			if (rd_idx >= exp_q.size()) begin
				beat_err++;
				$display("unexpected output beat %h at %0t ns, nothing was expected",
					o_vid_beat, $time);
			end else begin
				if (o_vid_beat !== exp_q[rd_idx]) begin
					beat_err++;
					$display("mismatch at %0t ns: o_vid_beat got %h expected %h",
						$time, o_vid_beat, exp_q[rd_idx]);
				end
				// Window of the transfer edge as counted from reset release
				if (exp_q[rd_idx].hlast && exp_q[rd_idx].vlast) begin
					ofs = edge_cnt + 1 - rel_base;
					frame_ends[(ofs / TICKS) % 64]++;
				end
				rd_idx++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Bus and stream tasks
	//////////////////////////////////////////////////////////////////////

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// One request with the ack expected two edges later
	task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, output logic [31:0] rdat, output int req_ofs);
		@(posedge i_clk);
		i_wb_cyc <= 1'b1;
		i_wb_stb <= 1'b1;
		i_wb_we <= we;
		i_wb_addr <= adr;
		i_wb_data <= dat;
		i_wb_sel <= sel;
		@(posedge i_clk);
		req_ofs = edge_cnt + 1 - rel_base;
		i_wb_stb <= 1'b0;
		@(negedge i_clk);
		if (o_wb_ack) begin
			err_cnt++;
			$display("bus ack came one cycle after the request at %0t ns", $time);
		end
		@(posedge i_clk);
		@(negedge i_clk);
		if (!o_wb_ack) begin
			err_cnt++;
			$display("bus ack missing two cycles after the request at %0t ns", $time);
		end
		rdat = o_wb_data;
		@(posedge i_clk);
		i_wb_cyc <= 1'b0;
	endtask

	task automatic write_reg(input logic [3:0] adr, input logic [31:0] dat,
		input logic [3:0] sel);
		logic [31:0] unused_data;
		int unused_ofs;
		bus_cycle(1'b1, adr, dat, sel, unused_data, unused_ofs);
	endtask

	// Frames counted in the window before the last pulse seen by the request
	function automatic int expected_fps(input int req_ofs);
		int k;
		k = (req_ofs - 1) / TICKS;
		if (k == 0)
			return 0;
		return (frame_ends[(k - 1) % 64] > 255) ? 255 : frame_ends[(k - 1) % 64];
	endfunction

	task automatic check_fps();
		logic [31:0] rd;
		int ofs;
		bus_cycle(1'b0, vidpipe_pkg::ADR_FPS, 32'h0, 4'hf, rd, ofs);
		compare_word("ADR_FPS readback", rd, expected_fps(ofs));
	endtask

	// Called on a rising edge and returns on the transfer edge
	task automatic send_pixel(input vidpipe_pkg::rgb_t p);
		if (({$random(src_seed)} % 4) == 0) begin
			i_pix_valid <= 1'b0;
			@(posedge i_clk);
		end
		i_pix_valid <= 1'b1;
		i_pixel <= p;
		do @(negedge i_clk); while (!o_pix_ready);
		@(posedge i_clk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] rd;
		int ofs;
		vidpipe_pkg::vid_apix_t beat;
		vidpipe_pkg::rgb_t p;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_addr = '0;
		i_wb_data = '0;
		i_wb_sel = '0;
		i_pix_valid = 1'b0;
		i_pixel = '0;
		// Width, height, alpha, frames, ready drop percent
		rows[0] = '{12'd8, 12'd4, 2'd1, 8'd3, 8'd0};
		rows[1] = '{12'd4, 12'd3, 2'd2, 8'd6, 8'd30};
		rows[2] = '{12'd16, 12'd2, 2'd0, 8'd2, 8'd50};
		rows[3] = '{12'd5, 12'd5, 2'd3, 8'd4, 8'd20};
		rows[4] = '{12'd1, 12'd1, 2'd1, 8'd20, 8'd10};
		limit = 2000;
		foreach (rows[i])
			limit += int'(rows[i].width) * int'(rows[i].height) * int'(rows[i].frames) * 4;

		repeat (8) @(posedge i_clk);
		@(negedge i_clk);
		if (o_vid_valid || o_wb_ack) begin
			err_cnt++;
			$display("stream valid or bus ack high during reset at %0t ns", $time);
		end
		repeat (8) @(posedge i_clk);
		pix_reset_sys <= 1'b0;
		rel_base = edge_cnt + 1;
		@(negedge i_clk);
		compare_word("o_vid_valid", {31'h0, o_vid_valid}, 32'h0);
		compare_word("o_wb_ack", {31'h0, o_wb_ack}, 32'h0);
		compare_word("o_pix_ready", {31'h0, o_pix_ready}, 32'h1);

		// Stray write to an unused address must leave the defaults alone
		write_reg(4'h5, 32'hffff_ffff, 4'hf);
		bus_cycle(1'b0, vidpipe_pkg::ADR_SIZE, 32'h0, 4'hf, rd, ofs);
		compare_word("ADR_SIZE readback", rd, {4'h0, 12'd480, 4'h0, 12'd640});
		check_fps();
		bus_cycle(1'b0, 4'h5, 32'h0, 4'hf, rd, ofs);
		compare_word("unused address readback", rd, 32'h0);

		foreach (rows[ri]) begin
			drop_pct <= int'(rows[ri].drop_pct);
			write_reg(vidpipe_pkg::ADR_SIZE, {4'h0, rows[ri].height, 4'h0, rows[ri].width}, 4'hf);
			// Only bits 15:14 of byte 1 land
			write_reg(vidpipe_pkg::ADR_CONTROL, {16'hffff, rows[ri].alpha, 14'h3fff}, 4'b0010);
			bus_cycle(1'b0, vidpipe_pkg::ADR_SIZE, 32'h0, 4'hf, rd, ofs);
			compare_word("ADR_SIZE readback", rd, {4'h0, rows[ri].height, 4'h0, rows[ri].width});
			bus_cycle(1'b0, vidpipe_pkg::ADR_CONTROL, 32'h0, 4'hf, rd, ofs);
			compare_word("ADR_CONTROL readback", rd, {16'h0, rows[ri].alpha, 14'h0});

			@(posedge i_clk);
			for (int f = 0; f < int'(rows[ri].frames); f++)
				for (int r = 0; r < int'(rows[ri].height); r++)
					for (int c = 0; c < int'(rows[ri].width); c++) begin
						// About one black pixel in four
						p = vidpipe_pkg::rgb_t'($random(src_seed));
						if (({$random(src_seed)} % 4) == 0)
							p = '0;
						beat.rgb = p;
						beat.hlast = (c == int'(rows[ri].width) - 1);
						beat.vlast = beat.hlast && (r == int'(rows[ri].height) - 1);
						beat.alpha = (p == vidpipe_pkg::TRANSPARENT) ? vidpipe_pkg::ALPHA_CLEAR
							: rows[ri].alpha;
						exp_q.push_back(beat);
						send_pixel(p);
					end
			i_pix_valid <= 1'b0;
			while (rd_idx != exp_q.size())
				@(negedge i_clk);
			check_fps();
		end

		// Idle past one more pulse for the last window
		drop_pct <= 0;
		repeat (TICKS) @(posedge i_clk);
		check_fps();

		$display("bus checks %0d, beats %0d of %0d, errors %0d",
			check_cnt, rd_idx, exp_q.size(), err_cnt + beat_err);
		if (err_cnt + beat_err == 0 && rd_idx == exp_q.size())
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: vidpipe.f
logic/vidpipe_pkg.sv
logic/vid_ctrl_regs.sv
logic/vid_framer.sv
logic/vid_alpha_skid.sv
logic/vid_frame_rate.sv
logic/vidpipe.sv
testbench/vidpipe_tb.sv

// File: Makefile
SRCS := $(shell grep -v '^+' vidpipe.f)

.PHONY: all run clean

all: run

obj_dir/Vvidpipe_tb: vidpipe.f $(SRCS)
	verilator --binary --timing --top-module vidpipe_tb -f vidpipe.f

run: obj_dir/Vvidpipe_tb
	./obj_dir/Vvidpipe_tb | tee sim.log
	grep -qx 'TEST OK' sim.log

clean:
	rm -rf obj_dir sim.log
